/* common/isa_pkg.sv */
// MIPS subset encodings
package isa_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDIU = 6'h09,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

	typedef struct packed {
		opcode_e    op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e     op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		opcode_e     op;
		logic [25:0] target26;
	} j_fmt_t;

	// One fetched word, seen in whichever format the opcode calls for.
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

endpackage

/* common/pipe_pkg.sv */
// Pipeline register and trace types
package pipe_pkg;

	typedef struct packed {
		logic             reg_dst;    // Destination is rd and funct picks the ALU op.
		logic             alu_src;    // Second ALU operand is the extended immediate.
		logic             mem_to_reg;
		logic             reg_wr;
		logic             mem_wr;
		logic             ext_signed;
		isa_pkg::alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		logic [31:0]     pc_plus_4;
		isa_pkg::instr_u instr;
		logic            valid;
	} if_id_t;

	typedef struct packed {
		ctrl_t           ctrl;
		logic [31:0]     bus_a;
		logic [31:0]     bus_b;
		logic [4:0]      rs;
		logic [4:0]      rt;
		logic [4:0]      rd;
		logic [15:0]     imm16;
		isa_pkg::funct_e funct;
		logic            valid;
	} id_ex_t;

	typedef struct packed {
		logic        reg_wr;
		logic        mem_to_reg;
		logic        mem_wr;
		logic [31:0] alu_out;
		logic [31:0] store_data;
		logic [4:0]  rw;
		logic        valid;
	} ex_mem_t;

	typedef struct packed {
		logic        reg_wr;
		logic        mem_to_reg;
		logic [31:0] alu_out;
		logic [31:0] mem_data;
		logic [4:0]  rw;
		logic        valid;
	} mem_wb_t;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

	// Writeback bus, which is also the commit trace.
	typedef struct packed {
		logic        valid;
		logic [4:0]  rw;
		logic [31:0] data;
	} wb_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] data;
	} store_t;

	function automatic logic [31:0] fwd_pick(input fwd_sel_e sel, input logic [31:0] reg_val,
			input logic [31:0] mem_val, input logic [31:0] wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

endpackage

/* fetch/fetch_stage.sv */
// Instruction fetch
`timescale 1ns/1ns

module fetch_stage #(
	parameter int IMEM_WORDS = 256
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          stall,
	input  logic                          redirect,
	input  logic [31:0]                   npc,
	input  logic                          boot_we,
	input  logic [$clog2(IMEM_WORDS)-1:0] boot_addr,
	input  logic [31:0]                   boot_data,
	output pipe_pkg::if_id_t              if_id
);

	localparam int AW = $clog2(IMEM_WORDS);

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] pc;
	logic [31:0] pc_plus_4;

	assign pc_plus_4 = pc + 32'd4;

	// The program is written in while the core sits in reset.
	always_ff @(posedge clk) begin
		if (rst && boot_we) begin
			imem[boot_addr] <= boot_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			if_id.valid <= 1'b0;
		end else if (!stall) begin
			pc <= redirect ? npc : pc_plus_4;
			if_id.valid <= !redirect; // The fall-through word is dropped on a taken jump.
			if_id.pc_plus_4 <= pc_plus_4;
			if_id.instr <= imem[pc[AW+1:2]];
		end
	end

endmodule

/* decode/reg_file.sv */
// General purpose register file
`timescale 1ns/1ns

module reg_file (
	input  logic          clk,
	input  logic [4:0]    ra,
	input  logic [4:0]    rb,
	input  pipe_pkg::wb_t wb,
	output logic [31:0]   bus_a,
	output logic [31:0]   bus_b
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (wb.valid) begin
			regs[wb.rw] <= wb.data; // wb.valid is never set for register 0.
		end
	end

	// A write in the same cycle shows through to the readers.
	assign bus_a = (ra == 5'd0) ? 32'd0 : (wb.valid && wb.rw == ra) ? wb.data : regs[ra];
	assign bus_b = (rb == 5'd0) ? 32'd0 : (wb.valid && wb.rw == rb) ? wb.data : regs[rb];

endmodule

/* decode/decode_stage.sv */
// Instruction decode and branch resolution
`timescale 1ns/1ns

module decode_stage (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall,
	input  pipe_pkg::if_id_t   if_id,
	input  pipe_pkg::wb_t      wb,
	input  logic [31:0]        ex_mem_alu,
	input  pipe_pkg::fwd_sel_e bfwd_a,
	input  pipe_pkg::fwd_sel_e bfwd_b,
	output pipe_pkg::id_ex_t   id_ex,
	output logic [31:0]        npc,
	output logic               redirect,
	output logic [4:0]         rs,
	output logic [4:0]         rt,
	output logic               id_is_branch
);

	isa_pkg::instr_u ins;
	pipe_pkg::ctrl_t ctrl;
	logic [31:0]     bus_a;
	logic [31:0]     bus_b;
	logic [31:0]     cmp_a;
	logic [31:0]     cmp_b;
	logic [31:0]     br_target;
	logic [31:0]     j_target;
	logic            is_j;

	assign ins = if_id.instr;
	assign rs = ins.r.rs;
	assign rt = ins.r.rt;

	reg_file i_reg_file (
		.clk   (clk),
		.ra    (rs),
		.rb    (rt),
		.wb    (wb),
		.bus_a (bus_a),
		.bus_b (bus_b)
	);

	always_comb begin
		ctrl = '0;
		if (if_id.valid) begin
			case (ins.r.op)
				isa_pkg::OP_RTYPE: begin
					ctrl.reg_dst = 1'b1;
					ctrl.reg_wr = 1'b1;
				end
				isa_pkg::OP_ADDIU: begin
					ctrl.alu_src = 1'b1;
					ctrl.reg_wr = 1'b1;
					ctrl.ext_signed = 1'b1;
				end
				isa_pkg::OP_ORI: begin
					ctrl.alu_src = 1'b1;
					ctrl.reg_wr = 1'b1;
					ctrl.alu_op = isa_pkg::ALU_OR;
				end
				isa_pkg::OP_LUI: begin
					ctrl.alu_src = 1'b1;
					ctrl.reg_wr = 1'b1;
					ctrl.alu_op = isa_pkg::ALU_LUI;
				end
				isa_pkg::OP_LW: begin
					ctrl.alu_src = 1'b1;
					ctrl.mem_to_reg = 1'b1;
					ctrl.reg_wr = 1'b1;
					ctrl.ext_signed = 1'b1;
				end
				isa_pkg::OP_SW: begin
					ctrl.alu_src = 1'b1;
					ctrl.mem_wr = 1'b1;
					ctrl.ext_signed = 1'b1;
				end
				default: ; // beq and j write nothing past this stage.
			endcase
		end
	end

	assign is_j = if_id.valid && (ins.j.op == isa_pkg::OP_J);
	assign id_is_branch = if_id.valid && (ins.i.op == isa_pkg::OP_BEQ);

	// Branch operands may still be in flight.
	assign cmp_a = pipe_pkg::fwd_pick(bfwd_a, bus_a, ex_mem_alu, wb.data);
	assign cmp_b = pipe_pkg::fwd_pick(bfwd_b, bus_b, ex_mem_alu, wb.data);

	assign br_target = if_id.pc_plus_4 + {{14{ins.i.imm16[15]}}, ins.i.imm16, 2'b00};
	assign j_target = {if_id.pc_plus_4[31:28], ins.j.target26, 2'b00};
	assign npc = is_j ? j_target : br_target;
	assign redirect = !stall && (is_j || (id_is_branch && (cmp_a == cmp_b)));

	always_ff @(posedge clk) begin
		if (rst || stall) begin
			id_ex.valid <= 1'b0;
			id_ex.ctrl <= '0;
		end else begin
			id_ex.valid <= if_id.valid;
			id_ex.ctrl <= ctrl;
		end
		id_ex.bus_a <= bus_a;
		id_ex.bus_b <= bus_b;
		id_ex.rs <= ins.r.rs;
		id_ex.rt <= ins.r.rt;
		id_ex.rd <= ins.r.rd;
		id_ex.imm16 <= ins.i.imm16;
		id_ex.funct <= ins.r.funct;
	end

endmodule

/* execute/execute_stage.sv */
// Execute stage with ALU
`timescale 1ns/1ns

module execute_stage (
	input  logic               clk,
	input  logic               rst,
	input  pipe_pkg::id_ex_t   id_ex,
	input  pipe_pkg::fwd_sel_e fwd_a,
	input  pipe_pkg::fwd_sel_e fwd_b,
	input  logic [31:0]        ex_mem_alu,
	input  logic [31:0]        wb_data,
	output pipe_pkg::ex_mem_t  ex_mem
);

	logic [31:0]      ext_imm;
	logic [31:0]      op_a;
	logic [31:0]      op_b;
	logic [31:0]      alu_b;
	logic [31:0]      alu_out;
	logic [4:0]       rw;
	isa_pkg::alu_op_e alu_ctl;

	assign ext_imm = id_ex.ctrl.ext_signed ? {{16{id_ex.imm16[15]}}, id_ex.imm16}
		: {16'h0000, id_ex.imm16};

	assign op_a = pipe_pkg::fwd_pick(fwd_a, id_ex.bus_a, ex_mem_alu, wb_data);
	assign op_b = pipe_pkg::fwd_pick(fwd_b, id_ex.bus_b, ex_mem_alu, wb_data);
	assign alu_b = id_ex.ctrl.alu_src ? ext_imm : op_b;
	assign rw = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

	// R-type instructions take their operation from funct.
	always_comb begin
		alu_ctl = id_ex.ctrl.alu_op;
		if (id_ex.ctrl.reg_dst) begin
			case (id_ex.funct)
				isa_pkg::F_SUBU: alu_ctl = isa_pkg::ALU_SUB;
				isa_pkg::F_AND:  alu_ctl = isa_pkg::ALU_AND;
				isa_pkg::F_OR:   alu_ctl = isa_pkg::ALU_OR;
				isa_pkg::F_SLT:  alu_ctl = isa_pkg::ALU_SLT;
				default:         alu_ctl = isa_pkg::ALU_ADD;
			endcase
		end
	end

	always_comb begin
		case (alu_ctl)
			isa_pkg::ALU_SUB: alu_out = op_a - alu_b;
			isa_pkg::ALU_AND: alu_out = op_a & alu_b;
			isa_pkg::ALU_OR:  alu_out = op_a | alu_b;
			isa_pkg::ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
			isa_pkg::ALU_LUI: alu_out = {alu_b[15:0], 16'h0000};
			default:          alu_out = op_a + alu_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
			ex_mem.reg_wr <= 1'b0;
			ex_mem.mem_to_reg <= 1'b0;
			ex_mem.mem_wr <= 1'b0;
		end else begin
			ex_mem.valid <= id_ex.valid;
			ex_mem.reg_wr <= id_ex.ctrl.reg_wr;
			ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
			ex_mem.mem_wr <= id_ex.ctrl.mem_wr;
		end
		ex_mem.alu_out <= alu_out;
		ex_mem.store_data <= op_b; // The forwarded rt value is what sw writes.
		ex_mem.rw <= rw;
	end

endmodule

/* rtl/memory_stage.sv */
// Data memory and writeback
`timescale 1ns/1ns

module memory_stage #(
	parameter int DMEM_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst,
	input  pipe_pkg::ex_mem_t ex_mem,
	output pipe_pkg::wb_t     wb,
	output logic              mem_wb_mem_to_reg,
	output pipe_pkg::store_t  store
);

	localparam int AW = $clog2(DMEM_WORDS);

	logic [31:0]       dmem [DMEM_WORDS];
	logic [AW-1:0]     idx;
	logic              write;
	pipe_pkg::mem_wb_t mem_wb;

	assign idx = ex_mem.alu_out[AW+1:2]; // Word addressed.
	assign write = ex_mem.valid && ex_mem.mem_wr;

	always_ff @(posedge clk) begin
		if (write) begin
			dmem[idx] <= ex_mem.store_data;
		end
	end

	assign store.valid = write;
	assign store.addr = ex_mem.alu_out;
	assign store.data = ex_mem.store_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wb.valid <= 1'b0;
			mem_wb.reg_wr <= 1'b0;
			mem_wb.mem_to_reg <= 1'b0;
		end else begin
			mem_wb.valid <= ex_mem.valid;
			mem_wb.reg_wr <= ex_mem.reg_wr;
			mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
		end
		mem_wb.alu_out <= ex_mem.alu_out;
		mem_wb.mem_data <= dmem[idx];
		mem_wb.rw <= ex_mem.rw;
	end

	assign mem_wb_mem_to_reg = mem_wb.mem_to_reg;

	// Writes to register 0 are dropped here, so they never reach the trace.
	assign wb.valid = mem_wb.valid && mem_wb.reg_wr && (mem_wb.rw != 5'd0);
	assign wb.rw = mem_wb.rw;
	assign wb.data = mem_wb.mem_to_reg ? mem_wb.mem_data : mem_wb.alu_out;

endmodule

/* rtl/hazard_unit.sv */
// Stall and forwarding control
`timescale 1ns/1ns

module hazard_unit (
	input  logic [4:0]         rs,
	input  logic [4:0]         rt,
	input  logic               id_is_branch,
	input  pipe_pkg::id_ex_t   id_ex,
	input  pipe_pkg::ex_mem_t  ex_mem,
	input  pipe_pkg::wb_t      wb,
	input  logic               mem_wb_mem_to_reg,
	output logic               stall,
	output pipe_pkg::fwd_sel_e fwd_a,
	output pipe_pkg::fwd_sel_e fwd_b,
	output pipe_pkg::fwd_sel_e bfwd_a,
	output pipe_pkg::fwd_sel_e bfwd_b
);

	logic [4:0] ex_rw;
	logic       ex_writes;
	logic       mem_writes;
	logic       load_use;
	logic       branch_ex;
	logic       branch_load;

	assign ex_rw = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
	assign ex_writes = id_ex.valid && id_ex.ctrl.reg_wr && (ex_rw != 5'd0);
	assign mem_writes = ex_mem.valid && ex_mem.reg_wr && (ex_mem.rw != 5'd0);

	// Load data only exists after MEM, so its first user waits a cycle.
	assign load_use = ex_writes && id_ex.ctrl.mem_to_reg && (ex_rw == rs || ex_rw == rt);

	// The compare sits in decode and cannot see a result still being computed in EX.
	assign branch_ex = id_is_branch && ex_writes && (ex_rw == rs || ex_rw == rt);
	assign branch_load = id_is_branch && mem_writes && ex_mem.mem_to_reg
		&& (ex_mem.rw == rs || ex_mem.rw == rt);

	assign stall = load_use || branch_ex || branch_load;

	always_comb begin
		fwd_a = pipe_pkg::FWD_REG;
		if (mem_writes && ex_mem.rw == id_ex.rs) begin
			fwd_a = pipe_pkg::FWD_MEM; // The newer value wins.
		end else if (wb.valid && wb.rw == id_ex.rs) begin
			fwd_a = pipe_pkg::FWD_WB;
		end
	end

	always_comb begin
		fwd_b = pipe_pkg::FWD_REG;
		if (mem_writes && ex_mem.rw == id_ex.rt) begin
			fwd_b = pipe_pkg::FWD_MEM;
		end else if (wb.valid && wb.rw == id_ex.rt) begin
			fwd_b = pipe_pkg::FWD_WB;
		end
	end

	// Writeback values already reach the branch through the register file.
	assign bfwd_a = (mem_writes && ex_mem.rw == rs) ? pipe_pkg::FWD_MEM : pipe_pkg::FWD_REG;
	assign bfwd_b = (mem_writes && ex_mem.rw == rt) ? pipe_pkg::FWD_MEM : pipe_pkg::FWD_REG;

endmodule

/* rtl/mips_pipe.sv */
// Five-stage MIPS pipeline
`timescale 1ns/1ns

module mips_pipe #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          boot_we,
	input  logic [$clog2(IMEM_WORDS)-1:0] boot_addr,
	input  logic [31:0]                   boot_data,
	output pipe_pkg::wb_t                 commit,
	output pipe_pkg::store_t              store
);

	pipe_pkg::if_id_t   if_id;
	pipe_pkg::id_ex_t   id_ex;
	pipe_pkg::ex_mem_t  ex_mem;
	pipe_pkg::wb_t      wb;
	pipe_pkg::fwd_sel_e fwd_a;
	pipe_pkg::fwd_sel_e fwd_b;
	pipe_pkg::fwd_sel_e bfwd_a;
	pipe_pkg::fwd_sel_e bfwd_b;
	logic [31:0]        npc;
	logic               redirect;
	logic               stall;
	logic               id_is_branch;
	logic               mem_wb_mem_to_reg;
	logic [4:0]         id_rs;
	logic [4:0]         id_rt;

	assign commit = wb; // Every register write that retires is visible here.

	fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) i_fetch (
		.clk       (clk),
		.rst       (rst),
		.stall     (stall),
		.redirect  (redirect),
		.npc       (npc),
		.boot_we   (boot_we),
		.boot_addr (boot_addr),
		.boot_data (boot_data),
		.if_id     (if_id)
	);

	decode_stage i_decode (
		.clk          (clk),
		.rst          (rst),
		.stall        (stall),
		.if_id        (if_id),
		.wb           (wb),
		.ex_mem_alu   (ex_mem.alu_out),
		.bfwd_a       (bfwd_a),
		.bfwd_b       (bfwd_b),
		.id_ex        (id_ex),
		.npc          (npc),
		.redirect     (redirect),
		.rs           (id_rs),
		.rt           (id_rt),
		.id_is_branch (id_is_branch)
	);

	execute_stage i_execute (
		.clk        (clk),
		.rst        (rst),
		.id_ex      (id_ex),
		.fwd_a      (fwd_a),
		.fwd_b      (fwd_b),
		.ex_mem_alu (ex_mem.alu_out),
		.wb_data    (wb.data),
		.ex_mem     (ex_mem)
	);

	memory_stage #(.DMEM_WORDS(DMEM_WORDS)) i_memory (
		.clk               (clk),
		.rst               (rst),
		.ex_mem            (ex_mem),
		.wb                (wb),
		.mem_wb_mem_to_reg (mem_wb_mem_to_reg),
		.store             (store)
	);

	hazard_unit i_hazard (
		.rs                (id_rs),
		.rt                (id_rt),
		.id_is_branch      (id_is_branch),
		.id_ex             (id_ex),
		.ex_mem            (ex_mem),
		.wb                (wb),
		.mem_wb_mem_to_reg (mem_wb_mem_to_reg),
		.stall             (stall),
		.fwd_a             (fwd_a),
		.fwd_b             (fwd_b),
		.bfwd_a            (bfwd_a),
		.bfwd_b            (bfwd_b)
	);

endmodule

/* testbench/tb_model.svh */
// Reference model of the MIPS subset
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Runs the current program from word 0 up to the closing self-jump.
// Expected commits and stores are queued in program order.
task automatic run_model();
	isa_pkg::instr_u  w;
	pipe_pkg::wb_t    c;
	pipe_pkg::store_t s;
	logic [31:0]      a;
	logic [31:0]      b;
	logic [31:0]      res;
	logic [31:0]      addr;
	logic [31:0]      sext;
	logic [4:0]       dest;
	logic             wr;
	int               pc;
	pc = 0;
	while (pc != PROG_LEN - 1) begin
		w = prog[pc];
		a = model_regs[w.r.rs];
		b = model_regs[w.r.rt];
		sext = {{16{w.i.imm16[15]}}, w.i.imm16};
		dest = w.i.rt;
		wr = 1'b0;
		res = '0;
		pc = pc + 1;
		case (w.r.op)
			isa_pkg::OP_RTYPE: begin
				wr = 1'b1;
				dest = w.r.rd;
				case (w.r.funct)
					isa_pkg::F_ADDU: res = a + b;
					isa_pkg::F_SUBU: res = a - b;
					isa_pkg::F_AND:  res = a & b;
					isa_pkg::F_OR:   res = a | b;
					isa_pkg::F_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:         res = '0;
				endcase
			end
			isa_pkg::OP_ADDIU: begin
				wr = 1'b1;
				res = a + sext;
			end
			isa_pkg::OP_ORI: begin
				wr = 1'b1;
				res = a | {16'h0000, w.i.imm16};
			end
			isa_pkg::OP_LUI: begin
				wr = 1'b1;
				res = {w.i.imm16, 16'h0000};
			end
			isa_pkg::OP_LW: begin
				wr = 1'b1;
				addr = a + sext;
				res = model_mem[int'(addr >> 2)];
			end
			isa_pkg::OP_SW: begin
				addr = a + sext;
				model_mem[int'(addr >> 2)] = b;
				s.valid = 1'b1;
				s.addr = addr;
				s.data = b;
				exp_stores.push_back(s);
			end
			isa_pkg::OP_BEQ: begin
				if (a == b) begin
					pc = pc + int'($signed(sext)); // Offset counts from the next word.
				end
			end
			isa_pkg::OP_J: pc = int'(w.j.target26);
			default: ;
		endcase
		if (wr && dest != 5'd0) begin
			model_regs[dest] = res;
			c.valid = 1'b1;
			c.rw = dest;
			c.data = res;
			exp_commits.push_back(c);
		end
	end
endtask

`endif

/* testbench/tb_mips.sv */
// Pipeline testbench
`timescale 1ns/1ns

module tb_mips;

	localparam int          IMEM_WORDS = 256;
	localparam int          DMEM_WORDS = 256;
	localparam int          IMEM_AW = $clog2(IMEM_WORDS);
	localparam int          NUM_PROGS = 8;
	localparam int          PROG_LEN = 60;
	localparam int          POOL_SIZE = 8;
	localparam int          RESET_CYCLES = 5;
	localparam int          DRAIN_CYCLES = 8;
	localparam int          TIMEOUT = NUM_PROGS * (PROG_LEN * 4 + 40);
	localparam logic [31:0] SEED = 32'h64f1_1352;

	logic               clk;
	logic               rst;
	logic               boot_we;
	logic [IMEM_AW-1:0] boot_addr;
	logic [31:0]        boot_data;
	pipe_pkg::wb_t      commit;
	pipe_pkg::store_t   store;

	logic [31:0]      prog [PROG_LEN];
	int               pool [POOL_SIZE];
	logic [31:0]      model_regs [32];
	logic [31:0]      model_mem [int];
	pipe_pkg::wb_t    exp_commits [$];
	pipe_pkg::store_t exp_stores [$];

	int cur_prog = 0;
	int cycles = 0;
	int commit_errors = 0;
	int store_errors = 0;
	int other_errors = 0;

	`include "tb_model.svh"

	mips_pipe #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) i_dut (
		.clk       (clk),
		.rst       (rst),
		.boot_we   (boot_we),
		.boot_addr (boot_addr),
		.boot_data (boot_data),
		.commit    (commit),
		.store     (store)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] enc_r(input isa_pkg::funct_e f, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		isa_pkg::instr_u w;
		w = '0;
		w.r.op = isa_pkg::OP_RTYPE;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.funct = f;
		return w;
	endfunction

	function automatic logic [31:0] enc_i(input isa_pkg::opcode_e op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		isa_pkg::instr_u w;
		w = '0;
		w.i.op = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm16 = imm;
		return w;
	endfunction

	function automatic logic [31:0] enc_j(input logic [25:0] target);
		isa_pkg::instr_u w;
		w = '0;
		w.j.op = isa_pkg::OP_J;
		w.j.target26 = target;
		return w;
	endfunction

	// A prologue sets r1 to r7 and fills a pool of data words, so nothing reads unknowns.
	task automatic gen_program();
		logic [4:0] d;
		logic [4:0] s;
		logic [4:0] t;
		logic [15:0] off;
		int lim;
		for (int k = 1; k < 8; k++) begin
			prog[k-1] = enc_i(isa_pkg::OP_ADDIU, 5'(k), 5'd0, 16'($urandom));
		end
		for (int k = 0; k < POOL_SIZE; k++) begin
			pool[k] = int'($urandom % DMEM_WORDS);
			prog[7+k] = enc_i(isa_pkg::OP_SW, 5'($urandom % 8), 5'd0, 16'(pool[k] * 4));
		end
		for (int i = 7 + POOL_SIZE; i < PROG_LEN - 1; i++) begin
			d = 5'($urandom % 8);
			s = 5'($urandom % 8);
			t = 5'($urandom % 8);
			off = 16'(pool[$urandom % POOL_SIZE] * 4);
			lim = PROG_LEN - 2 - i; // Largest skip that stays inside the program.
			if (lim > 3) begin
				lim = 3;
			end
			case ($urandom % 12)
				0:  prog[i] = enc_r(isa_pkg::F_ADDU, d, s, t);
				1:  prog[i] = enc_r(isa_pkg::F_SUBU, d, s, t);
				2:  prog[i] = enc_r(isa_pkg::F_AND, d, s, t);
				3:  prog[i] = enc_r(isa_pkg::F_OR, d, s, t);
				4:  prog[i] = enc_r(isa_pkg::F_SLT, d, s, t);
				5:  prog[i] = enc_i(isa_pkg::OP_ADDIU, d, s, 16'($urandom));
				6:  prog[i] = enc_i(isa_pkg::OP_ORI, d, s, 16'($urandom));
				7:  prog[i] = enc_i(isa_pkg::OP_LUI, d, 5'd0, 16'($urandom));
				8:  prog[i] = enc_i(isa_pkg::OP_LW, d, 5'd0, off);
				9:  prog[i] = enc_i(isa_pkg::OP_SW, t, 5'd0, off);
				10: prog[i] = enc_i(isa_pkg::OP_BEQ, t, s, 16'($urandom % (lim + 1)));
				default: prog[i] = enc_j(26'(i + 1 + int'($urandom % (lim + 1))));
			endcase
		end
		prog[PROG_LEN-1] = enc_j(26'(PROG_LEN - 1));
	endtask

	// The core stays in reset while the boot port writes the program.
	task automatic load_program();
		@(posedge clk);
		rst <= 1'b1;
		for (int k = 0; k < PROG_LEN; k++) begin
			@(posedge clk);
			boot_we <= 1'b1;
			boot_addr <= IMEM_AW'(k);
			boot_data <= prog[k];
		end
		@(posedge clk);
		boot_we <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	endtask

	// Traces mark completion, so the program is done once both queues have drained.
	task automatic wait_retire();
		while (exp_commits.size() != 0 || exp_stores.size() != 0) begin
			@(posedge clk);
		end
		repeat (DRAIN_CYCLES) @(posedge clk); // Late extra traces still get caught.
	endtask

	task automatic check_commit(input pipe_pkg::wb_t got);
		pipe_pkg::wb_t exp;
		if (exp_commits.size() == 0) begin
			$display("Program %0d wrote r%0d after the model had no commits left",
				cur_prog, got.rw);
			other_errors++;
		end else begin
			exp = exp_commits.pop_front();
			if (got.rw !== exp.rw) begin
				$display("FAILED commit.rw: got %h, expected %h", got.rw, exp.rw);
				commit_errors++;
			end
			if (got.data !== exp.data) begin
				$display("FAILED commit.data: got %h, expected %h", got.data, exp.data);
				commit_errors++;
			end
		end
	endtask

	task automatic check_store(input pipe_pkg::store_t got);
		pipe_pkg::store_t exp;
		if (exp_stores.size() == 0) begin
			$display("Program %0d stored to %h after the model had no stores left",
				cur_prog, got.addr);
			other_errors++;
		end else begin
			exp = exp_stores.pop_front();
			if (got.addr !== exp.addr) begin
				$display("FAILED store.addr: got %h, expected %h", got.addr, exp.addr);
				store_errors++;
			end
			if (got.data !== exp.data) begin
				$display("FAILED store.data: got %h, expected %h", got.data, exp.data);
				store_errors++;
			end
		end
	endtask

	// Traces settle after the rising edge, so they are sampled on the falling one.
	always @(negedge clk) begin
		if (!rst) begin
			if (commit.valid) begin
				check_commit(commit);
			end
			if (store.valid) begin
				check_store(store);
			end
		end
	end

	always @(posedge clk) begin
		if (!rst) begin
			cycles++;
			if (cycles >= TIMEOUT) begin
				$display("Timeout after %0d running cycles in program %0d",
					cycles, cur_prog);
				$display("Program %0d still had %0d commits and %0d stores not seen",
					cur_prog, exp_commits.size(), exp_stores.size());
				$display("Checks failed");
				$finish;
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		boot_we = 1'b0;
		boot_addr = '0;
		boot_data = '0;
		void'($urandom(SEED));
		for (int k = 0; k < 32; k++) begin
			model_regs[k] = '0;
		end
		for (int p = 0; p < NUM_PROGS; p++) begin
			cur_prog = p;
			gen_program();
			run_model();
			load_program();
			wait_retire();
		end
		$display("Errors: commit %0d, store %0d, other %0d",
			commit_errors, store_errors, other_errors);
		if (commit_errors + store_errors + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+testbench
common/isa_pkg.sv
common/pipe_pkg.sv
fetch/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/mips_pipe.sv
testbench/tb_mips.sv

/* run.sh */
#!/bin/sh
verilator --binary -j 0 --top-module tb_mips -f sim.f -Mdir obj_dir -o tb_mips > sim.log 2>&1 &&
	./obj_dir/tb_mips >> sim.log 2>&1 &&
	! grep -q "Checks failed" sim.log ||
	{ cat sim.log; exit 1; }
cat sim.log
exit 0
